// File: logic/spi_host_pkg.sv
package spi_host_pkg;

  // Queue and FIFO sizes
  localparam int CmdDepth  = 4;
  localparam int FifoDepth = 16;

  // Error classes, one sticky status bit each
  localparam int NumErrors    = 3;
  localparam int ErrBusy      = 0;
  localparam int ErrOverflow  = 1;
  localparam int ErrUnderflow = 2;

  // Status event sources for the spi_event interrupt
  localparam int NumEvents = 6;
  localparam int EvIdle    = 0;
  localparam int EvReady   = 1;
  localparam int EvTxWm    = 2;
  localparam int EvRxWm    = 3;
  localparam int EvTxEmpty = 4;
  localparam int EvRxFull  = 5;

  typedef logic [7:0] byte_t;

  // Segment length in bytes, minus one
  typedef logic [7:0] len_t;

  // SCK half period minus one, in system clocks
  typedef logic [7:0] clkdiv_t;

  // Fill level, wide enough to hold a full FIFO
  typedef logic [4:0] qd_t;

  typedef logic [NumErrors-1:0] err_vec_t;
  typedef logic [NumEvents-1:0] ev_vec_t;

  typedef enum logic [1:0] {
    DirRx    = 2'd1,
    DirTx    = 2'd2,
    DirBidir = 2'd3
  } dir_e;

  typedef enum logic [2:0] {
    StIdle,
    StLead,
    StShift,
    StTrail,
    StHold
  } engine_state_e;

endpackage

// File: logic/spi_host_cmd_queue.sv
`timescale 1ns/1ns

module spi_host_cmd_queue (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                sw_rst_i,
  input  logic                push_i,
  input  spi_host_pkg::len_t  len_i,
  input  spi_host_pkg::dir_e  dir_i,
  input  logic                csaat_i,
  input  logic                pop_i,
  output logic                head_valid_o,
  output spi_host_pkg::len_t  head_len_o,
  output spi_host_pkg::dir_e  head_dir_o,
  output logic                head_csaat_o,
  output logic                full_o,
  output spi_host_pkg::qd_t   depth_o
);

  spi_host_pkg::len_t len_mem   [spi_host_pkg::CmdDepth];
  spi_host_pkg::dir_e dir_mem   [spi_host_pkg::CmdDepth];
  logic               csaat_mem [spi_host_pkg::CmdDepth];

  logic [$clog2(spi_host_pkg::CmdDepth)-1:0] wr_ptr_q;
  logic [$clog2(spi_host_pkg::CmdDepth)-1:0] rd_ptr_q;
  spi_host_pkg::qd_t                         depth_q;
  logic                                      push_ok;
  logic                                      pop_ok;

  // Commands arriving while full are dropped, the top level flags them
  assign push_ok = push_i & ~full_o;
  assign pop_ok  = pop_i & head_valid_o;

  assign full_o       = depth_q == spi_host_pkg::qd_t'(spi_host_pkg::CmdDepth);
  assign head_valid_o = depth_q != '0;
  assign depth_o      = depth_q;
  assign head_len_o   = len_mem[rd_ptr_q];
  assign head_dir_o   = dir_mem[rd_ptr_q];
  assign head_csaat_o = csaat_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      len_mem[wr_ptr_q]   <= len_i;
      dir_mem[wr_ptr_q]   <= dir_i;
      csaat_mem[wr_ptr_q] <= csaat_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || sw_rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      depth_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == spi_host_pkg::CmdDepth - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == spi_host_pkg::CmdDepth - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_ok && !pop_ok) begin
        depth_q <= depth_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        depth_q <= depth_q - 1'b1;
      end
    end
  end

  // The engine only takes a command it has seen as valid
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> head_valid_o);

endmodule

// File: logic/spi_host_byte_fifo.sv
`timescale 1ns/1ns

module spi_host_byte_fifo #(
  parameter int Depth = spi_host_pkg::FifoDepth
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                sw_rst_i,
  input  logic                push_i,
  input  spi_host_pkg::byte_t data_i,
  input  logic                pop_i,
  output spi_host_pkg::byte_t data_o,
  output logic                empty_o,
  output logic                full_o,
  output spi_host_pkg::qd_t   depth_o
);

  spi_host_pkg::byte_t mem [Depth];

  logic [$clog2(Depth)-1:0] wr_ptr_q;
  logic [$clog2(Depth)-1:0] rd_ptr_q;
  spi_host_pkg::qd_t        depth_q;
  logic                     push_ok;
  logic                     pop_ok;

  assign push_ok = push_i & ~full_o;
  assign pop_ok  = pop_i & ~empty_o;

  assign empty_o = depth_q == '0;
  assign full_o  = depth_q == spi_host_pkg::qd_t'(Depth);
  assign depth_o = depth_q;

  // Head of the FIFO is always visible
  assign data_o = mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || sw_rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      depth_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == Depth - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == Depth - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_ok && !pop_ok) begin
        depth_q <= depth_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        depth_q <= depth_q - 1'b1;
      end
    end
  end

  a_depth_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    depth_q <= spi_host_pkg::qd_t'(Depth));

endmodule

// File: logic/spi_host_shift_engine.sv
`timescale 1ns/1ns

module spi_host_shift_engine (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  sw_rst_i,
  input  logic                  en_i,
  input  spi_host_pkg::clkdiv_t clkdiv_i,
  input  logic                  cpol_i,
  input  logic                  cpha_i,
  input  logic                  cmd_valid_i,
  input  spi_host_pkg::len_t    cmd_len_i,
  input  spi_host_pkg::dir_e    cmd_dir_i,
  input  logic                  cmd_csaat_i,
  input  logic                  tx_empty_i,
  input  spi_host_pkg::byte_t   tx_data_i,
  input  logic                  rx_full_i,
  input  logic                  sd_i,
  output logic                  cmd_pop_o,
  output logic                  tx_pop_o,
  output logic                  rx_push_o,
  output spi_host_pkg::byte_t   rx_data_o,
  output logic                  sck_o,
  output logic                  csb_o,
  output logic                  sd_o,
  output logic                  active_o
);

  spi_host_pkg::engine_state_e state_q;
  spi_host_pkg::clkdiv_t       hp_cnt_q;
  logic [3:0]                  bit_cnt_q;
  spi_host_pkg::len_t          byte_cnt_q;
  logic                        run_q;
  logic                        csb_q;
  spi_host_pkg::dir_e          dir_q;
  logic                        csaat_q;
  spi_host_pkg::byte_t         tx_sr_q;
  spi_host_pkg::byte_t         rx_sr_q;

  logic hp_tick;
  logic need_tx;
  logic need_rx;
  logic tx_stall;
  logic rx_stall;
  logic start_cmd;
  logic byte_start;
  logic byte_end;

  assign hp_tick  = hp_cnt_q >= clkdiv_i;
  assign need_tx  = dir_q != spi_host_pkg::DirRx;
  assign need_rx  = dir_q != spi_host_pkg::DirTx;

  // A byte only starts once its TX data and its RX slot are both there
  assign tx_stall = need_tx & tx_empty_i;
  assign rx_stall = need_rx & rx_full_i;

  // From idle the CSB gap must be over, from hold the next segment follows at once
  assign start_cmd  = en_i & cmd_valid_i &
                      ((state_q == spi_host_pkg::StIdle & hp_tick) |
                       state_q == spi_host_pkg::StHold);
  assign byte_start = (state_q == spi_host_pkg::StShift) & ~run_q & ~tx_stall & ~rx_stall;
  assign byte_end   = run_q & hp_tick & (bit_cnt_q == 4'd15);

  assign cmd_pop_o = start_cmd;
  assign tx_pop_o  = byte_start & need_tx;
  assign rx_push_o = byte_end & need_rx;
  assign rx_data_o = rx_sr_q;

  // Odd half periods are active for CPHA 0, even ones for CPHA 1
  assign sck_o    = cpol_i ^ (run_q & (bit_cnt_q[0] ^ cpha_i));
  assign sd_o     = run_q & tx_sr_q[7];
  assign csb_o    = csb_q;
  assign active_o = state_q != spi_host_pkg::StIdle;

  // Half-period timer, saturates in idle to time the CSB gap
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || sw_rst_i) begin
      hp_cnt_q <= '0;
    end else if (start_cmd || byte_start) begin
      hp_cnt_q <= '0;
    end else if (hp_tick && state_q != spi_host_pkg::StIdle) begin
      hp_cnt_q <= '0;
    end else if (!hp_tick) begin
      hp_cnt_q <= hp_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || sw_rst_i) begin
      state_q    <= spi_host_pkg::StIdle;
      bit_cnt_q  <= '0;
      byte_cnt_q <= '0;
      run_q      <= 1'b0;
      csb_q      <= 1'b1;
    end else begin
      unique case (state_q)
        spi_host_pkg::StIdle: begin
          if (start_cmd) begin
            state_q    <= spi_host_pkg::StLead;
            byte_cnt_q <= cmd_len_i;
            csb_q      <= 1'b0;
          end
        end
        spi_host_pkg::StLead: begin
          if (hp_tick) begin
            state_q <= spi_host_pkg::StShift;
          end
        end
        spi_host_pkg::StShift: begin
          if (byte_start) begin
            run_q     <= 1'b1;
            bit_cnt_q <= '0;
          end else if (run_q && hp_tick) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (byte_end) begin
              run_q <= 1'b0;
              if (byte_cnt_q == '0) begin
                state_q <= spi_host_pkg::StTrail;
              end else begin
                byte_cnt_q <= byte_cnt_q - 1'b1;
              end
            end
          end
        end
        spi_host_pkg::StTrail: begin
          if (hp_tick) begin
            if (csaat_q) begin
              state_q <= spi_host_pkg::StHold;
            end else begin
              state_q <= spi_host_pkg::StIdle;
              csb_q   <= 1'b1;
            end
          end
        end
        spi_host_pkg::StHold: begin
          // CSB stays low across the segment boundary
          if (start_cmd) begin
            state_q    <= spi_host_pkg::StShift;
            byte_cnt_q <= cmd_len_i;
          end
        end
        default: begin
          state_q <= spi_host_pkg::StIdle;
          csb_q   <= 1'b1;
        end
      endcase
    end
  end

  // Data launches at the end of odd half periods and is sampled at the end of even ones
  always_ff @(posedge clk_i) begin
    if (start_cmd) begin
      dir_q   <= cmd_dir_i;
      csaat_q <= cmd_csaat_i;
    end
    if (byte_start) begin
      tx_sr_q <= need_tx ? tx_data_i : '0;
    end else if (run_q && hp_tick) begin
      if (bit_cnt_q[0]) begin
        tx_sr_q <= {tx_sr_q[6:0], 1'b0};
      end else begin
        rx_sr_q <= {rx_sr_q[6:0], sd_i};
      end
    end
  end

  a_csb_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    state_q == spi_host_pkg::StIdle |-> csb_o);

  a_sck_parked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    csb_o |-> sck_o == cpol_i);

endmodule

// File: logic/spi_host_irq.sv
`timescale 1ns/1ns

module spi_host_irq (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  spi_host_pkg::err_vec_t err_strobe_i,
  input  spi_host_pkg::err_vec_t err_enable_i,
  input  logic                   err_clear_i,
  input  spi_host_pkg::err_vec_t err_clear_mask_i,
  input  logic                   active_i,
  input  logic                   cmd_full_i,
  input  spi_host_pkg::qd_t      tx_depth_i,
  input  spi_host_pkg::qd_t      rx_depth_i,
  input  spi_host_pkg::qd_t      tx_watermark_i,
  input  spi_host_pkg::qd_t      rx_watermark_i,
  input  logic                   tx_empty_i,
  input  logic                   rx_full_i,
  input  spi_host_pkg::ev_vec_t  event_enable_i,
  output spi_host_pkg::err_vec_t err_status_o,
  output logic                   halt_o,
  output logic                   intr_error_o,
  output logic                   intr_spi_event_o
);

  spi_host_pkg::err_vec_t err_status_q;
  spi_host_pkg::err_vec_t clear_bits;
  spi_host_pkg::ev_vec_t  events;
  logic                   intr_error_q;
  logic                   intr_event_q;

  assign clear_bits = err_clear_i ? err_clear_mask_i : '0;

  // A new error wins over a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      err_status_q <= '0;
      intr_error_q <= 1'b0;
    end else begin
      err_status_q <= (err_status_q & ~clear_bits) | err_strobe_i;
      intr_error_q <= |(err_status_q & err_enable_i);
    end
  end

  assign err_status_o = err_status_q;
  assign halt_o       = |err_status_q;
  assign intr_error_o = intr_error_q;

  // TX watermark fires at or below the level, RX at or above it
  always_comb begin
    events                          = '0;
    events[spi_host_pkg::EvIdle]    = ~active_i;
    events[spi_host_pkg::EvReady]   = ~cmd_full_i;
    events[spi_host_pkg::EvTxWm]    = tx_depth_i <= tx_watermark_i;
    events[spi_host_pkg::EvRxWm]    = rx_depth_i >= rx_watermark_i;
    events[spi_host_pkg::EvTxEmpty] = tx_empty_i;
    events[spi_host_pkg::EvRxFull]  = rx_full_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      intr_event_q <= 1'b0;
    end else begin
      intr_event_q <= |(events & event_enable_i);
    end
  end

  assign intr_spi_event_o = intr_event_q;

endmodule

// File: logic/spi_host.sv
`timescale 1ns/1ns

module spi_host (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   cmd_valid_i,
  input  spi_host_pkg::len_t     cmd_len_i,
  input  spi_host_pkg::dir_e     cmd_dir_i,
  input  logic                   cmd_csaat_i,
  input  logic                   tx_valid_i,
  input  spi_host_pkg::byte_t    tx_data_i,
  input  logic                   rx_ready_i,
  output spi_host_pkg::byte_t    rx_data_o,
  output logic                   rx_valid_o,
  input  logic                   err_clear_i,
  input  spi_host_pkg::err_vec_t err_clear_mask_i,
  input  logic                   spien_i,
  input  spi_host_pkg::clkdiv_t  clkdiv_i,
  input  logic                   cpol_i,
  input  logic                   cpha_i,
  input  spi_host_pkg::qd_t      tx_watermark_i,
  input  spi_host_pkg::qd_t      rx_watermark_i,
  input  spi_host_pkg::err_vec_t err_enable_i,
  input  spi_host_pkg::ev_vec_t  event_enable_i,
  input  logic                   sw_rst_i,
  output logic                   sck_o,
  output logic                   csb_o,
  output logic                   sd_o,
  input  logic                   sd_i,
  output logic                   ready_o,
  output logic                   active_o,
  output spi_host_pkg::qd_t      tx_qd_o,
  output spi_host_pkg::qd_t      rx_qd_o,
  output spi_host_pkg::qd_t      cmd_qd_o,
  output spi_host_pkg::err_vec_t err_status_o,
  output logic                   intr_error_o,
  output logic                   intr_spi_event_o
);

  logic                   head_valid;
  spi_host_pkg::len_t     head_len;
  spi_host_pkg::dir_e     head_dir;
  logic                   head_csaat;
  logic                   cmd_full;
  logic                   cmd_pop;
  spi_host_pkg::byte_t    tx_head;
  logic                   tx_empty;
  logic                   tx_full;
  logic                   tx_pop;
  spi_host_pkg::byte_t    rx_byte;
  logic                   rx_empty;
  logic                   rx_full;
  logic                   rx_push;
  logic                   halt;
  logic                   engine_en;
  spi_host_pkg::err_vec_t err_strobe;

  // Inputs have no back-pressure, so a strobe that cannot be taken is an error
  always_comb begin
    err_strobe                             = '0;
    err_strobe[spi_host_pkg::ErrBusy]      = cmd_valid_i & cmd_full;
    err_strobe[spi_host_pkg::ErrOverflow]  = tx_valid_i & tx_full;
    err_strobe[spi_host_pkg::ErrUnderflow] = rx_ready_i & rx_empty;
  end

  assign engine_en  = spien_i & ~halt;
  assign ready_o    = ~cmd_full;
  assign rx_valid_o = ~rx_empty;

  spi_host_cmd_queue u_cmd_queue (
    .clk_i,
    .rst_n_i,
    .sw_rst_i,
    .push_i       (cmd_valid_i),
    .len_i        (cmd_len_i),
    .dir_i        (cmd_dir_i),
    .csaat_i      (cmd_csaat_i),
    .pop_i        (cmd_pop),
    .head_valid_o (head_valid),
    .head_len_o   (head_len),
    .head_dir_o   (head_dir),
    .head_csaat_o (head_csaat),
    .full_o       (cmd_full),
    .depth_o      (cmd_qd_o)
  );

  spi_host_byte_fifo u_tx_fifo (
    .clk_i,
    .rst_n_i,
    .sw_rst_i,
    .push_i  (tx_valid_i),
    .data_i  (tx_data_i),
    .pop_i   (tx_pop),
    .data_o  (tx_head),
    .empty_o (tx_empty),
    .full_o  (tx_full),
    .depth_o (tx_qd_o)
  );

  spi_host_byte_fifo u_rx_fifo (
    .clk_i,
    .rst_n_i,
    .sw_rst_i,
    .push_i  (rx_push),
    .data_i  (rx_byte),
    .pop_i   (rx_ready_i),
    .data_o  (rx_data_o),
    .empty_o (rx_empty),
    .full_o  (rx_full),
    .depth_o (rx_qd_o)
  );

  spi_host_shift_engine u_engine (
    .clk_i,
    .rst_n_i,
    .sw_rst_i,
    .en_i        (engine_en),
    .clkdiv_i,
    .cpol_i,
    .cpha_i,
    .cmd_valid_i (head_valid),
    .cmd_len_i   (head_len),
    .cmd_dir_i   (head_dir),
    .cmd_csaat_i (head_csaat),
    .tx_empty_i  (tx_empty),
    .tx_data_i   (tx_head),
    .rx_full_i   (rx_full),
    .sd_i,
    .cmd_pop_o   (cmd_pop),
    .tx_pop_o    (tx_pop),
    .rx_push_o   (rx_push),
    .rx_data_o   (rx_byte),
    .sck_o,
    .csb_o,
    .sd_o,
    .active_o
  );

  spi_host_irq u_irq (
    .clk_i,
    .rst_n_i,
    .err_strobe_i     (err_strobe),
    .err_enable_i,
    .err_clear_i,
    .err_clear_mask_i,
    .active_i         (active_o),
    .cmd_full_i       (cmd_full),
    .tx_depth_i       (tx_qd_o),
    .rx_depth_i       (rx_qd_o),
    .tx_watermark_i,
    .rx_watermark_i,
    .tx_empty_i       (tx_empty),
    .rx_full_i        (rx_full),
    .event_enable_i,
    .err_status_o,
    .halt_o           (halt),
    .intr_error_o,
    .intr_spi_event_o
  );

  // The engine reserves the RX slot before each byte, so a push never meets a full FIFO
  a_rx_push_room: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rx_push |-> !rx_full);

endmodule

// File: bench/spi_host_tb.sv
`timescale 1ns/1ns

module spi_host_tb;

  localparam int CycleLimit = 40000;

  logic clk_i = 1'b0;
  logic rst_n_i = 1'b0;
  logic cmd_valid_i, cmd_csaat_i, tx_valid_i, rx_ready_i, err_clear_i;
  logic spien_i, cpol_i, cpha_i, sw_rst_i;
  logic sd_i = 1'b0;
  spi_host_pkg::len_t     cmd_len_i;
  spi_host_pkg::dir_e     cmd_dir_i;
  spi_host_pkg::byte_t    tx_data_i, rx_data_o;
  spi_host_pkg::err_vec_t err_clear_mask_i, err_enable_i, err_status_o;
  spi_host_pkg::clkdiv_t  clkdiv_i;
  spi_host_pkg::qd_t      tx_watermark_i, rx_watermark_i, tx_qd_o, rx_qd_o, cmd_qd_o;
  spi_host_pkg::ev_vec_t  event_enable_i;
  logic rx_valid_o, sck_o, csb_o, sd_o, ready_o, active_o, intr_error_o, intr_spi_event_o;

  int    errors = 0;
  int    checks = 0;
  int    cycles = 0;
  int    csb_rises = 0;
  string test_name = "reset";

  // Device model state
  spi_host_pkg::byte_t mosi_q[$];
  spi_host_pkg::byte_t mosi_sr = '0;
  int                  edge_cnt = 0;
  logic                sck_prev = 1'b0;

  spi_host i_dut (.*);

  initial begin
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("Timeout after %0d cycles in test %s", cycles, test_name);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  always @(posedge csb_o) begin
    csb_rises++;
  end

  // MISO bit n of a frame comes from byte n / 8 XOR 8'hA5 sent MSB first
  function automatic logic miso_bit(input int n);
    spi_host_pkg::byte_t b;
    b = spi_host_pkg::byte_t'(n / 8) ^ 8'hA5;
    return b[7 - (n % 8)];
  endfunction

  // The edge that moves SCK to cpol ^ ~cpha captures and the other edge launches
  always @(sck_o or csb_o) begin
    if (csb_o) begin
      edge_cnt = 0;
      sd_i = miso_bit(0);
    end else if (sck_o !== sck_prev) begin
      if (sck_o == (cpol_i ^ ~cpha_i)) begin
        mosi_sr = {mosi_sr[6:0], sd_o};
        edge_cnt++;
        if (edge_cnt % 8 == 0) mosi_q.push_back(mosi_sr);
      end else begin
        sd_i = miso_bit(edge_cnt);
      end
    end
    sck_prev = sck_o;
  end

  a_csb_needs_active: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !csb_o |-> active_o)
    else begin
      errors++;
      $display("** Error %s/csb: expected active 1, actual %0b", test_name, active_o);
    end

  a_sck_parked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    csb_o |-> sck_o == cpol_i)
    else begin
      errors++;
      $display("** Error %s/sck: expected %0b, actual %0b", test_name, cpol_i, sck_o);
    end

  task automatic check(input string label, input int exp, input int act);
    checks++;
    assert (exp == act)
    else begin
      errors++;
      $display("** Error %s/%s: expected %0h, actual %0h", test_name, label, exp, act);
    end
  endtask

  task automatic cycles_wait(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  task automatic push_tx(input spi_host_pkg::byte_t b);
    tx_valid_i = 1'b1;
    tx_data_i  = b;
    @(negedge clk_i);
    tx_valid_i = 1'b0;
  endtask

  task automatic push_cmd(input int len, input spi_host_pkg::dir_e dir, input logic csaat);
    cmd_valid_i = 1'b1;
    cmd_len_i   = spi_host_pkg::len_t'(len - 1);
    cmd_dir_i   = dir;
    cmd_csaat_i = csaat;
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
  endtask

  task automatic pop_rx(output spi_host_pkg::byte_t b);
    b = rx_data_o;
    rx_ready_i = 1'b1;
    @(negedge clk_i);
    rx_ready_i = 1'b0;
  endtask

  task automatic clear_errors(input spi_host_pkg::err_vec_t mask);
    err_clear_i      = 1'b1;
    err_clear_mask_i = mask;
    @(negedge clk_i);
    err_clear_i = 1'b0;
  endtask

  // Waits until the engine has started and every queued command is done
  task automatic drain_queue();
    while (!active_o) @(negedge clk_i);
    while (cmd_qd_o != '0 || active_o) @(negedge clk_i);
  endtask

  task automatic transfer_test(input string name, input spi_host_pkg::dir_e dir,
                               input logic pol, input logic pha);
    spi_host_pkg::byte_t exp_q[$];
    spi_host_pkg::byte_t b;
    int n;
    test_name = name;
    cpol_i = pol;
    cpha_i = pha;
    mosi_q.delete();
    n = 1 + $urandom_range(7);
    for (int i = 0; i < n; i++) begin
      b = spi_host_pkg::byte_t'($urandom);
      exp_q.push_back(b);
      if (dir != spi_host_pkg::DirRx) push_tx(b);
    end
    push_cmd(n, dir, 1'b0);
    drain_queue();
    if (dir != spi_host_pkg::DirRx) begin
      check("mosi count", n, mosi_q.size());
      for (int i = 0; i < n && i < mosi_q.size(); i++) check("mosi", exp_q[i], mosi_q[i]);
    end
    if (dir == spi_host_pkg::DirTx) begin
      check("rx depth", 0, int'(rx_qd_o));
      check("rx valid", 0, int'(rx_valid_o));
    end else begin
      check("rx depth", n, int'(rx_qd_o));
      check("rx valid", 1, int'(rx_valid_o));
      for (int i = 0; i < n; i++) begin
        pop_rx(b);
        check("miso", i ^ 8'hA5, b);
      end
    end
  endtask

  initial begin
    spi_host_pkg::byte_t b;
    void'($urandom(32'h2e5c38af));
    {cmd_valid_i, cmd_csaat_i, tx_valid_i, rx_ready_i, err_clear_i, sw_rst_i} = '0;
    {cpol_i, cpha_i} = 2'b00;
    spien_i = 1'b1;
    cmd_len_i = '0;
    cmd_dir_i = spi_host_pkg::DirTx;
    tx_data_i = '0;
    err_clear_mask_i = '0;
    err_enable_i = 3'b110;
    clkdiv_i = 8'd3;
    tx_watermark_i = 5'd2;
    rx_watermark_i = 5'd3;
    event_enable_i = '0;
    repeat (10) @(negedge clk_i);
    rst_n_i = 1'b1;
    cycles_wait(2);
    check("csb after reset", 1, int'(csb_o));
    check("ready after reset", 1, int'(ready_o));
    check("active after reset", 0, int'(active_o));
    check("rx valid after reset", 0, int'(rx_valid_o));

    transfer_test("write mode 0", spi_host_pkg::DirTx, 1'b0, 1'b0);
    transfer_test("write mode 3", spi_host_pkg::DirTx, 1'b1, 1'b1);
    transfer_test("read mode 0", spi_host_pkg::DirRx, 1'b0, 1'b0);
    transfer_test("bidir mode 1", spi_host_pkg::DirBidir, 1'b0, 1'b1);

    test_name = "csb framing";
    push_tx(8'h3c);
    push_tx(8'hc3);
    csb_rises = 0;
    push_cmd(1, spi_host_pkg::DirTx, 1'b1);
    push_cmd(1, spi_host_pkg::DirTx, 1'b0);
    drain_queue();
    check("rises with csaat", 1, csb_rises);
    push_tx(8'h11);
    push_tx(8'h22);
    csb_rises = 0;
    push_cmd(1, spi_host_pkg::DirTx, 1'b0);
    push_cmd(1, spi_host_pkg::DirTx, 1'b0);
    drain_queue();
    check("rises without csaat", 2, csb_rises);

    test_name = "errors";
    spien_i = 1'b0;
    for (int i = 0; i < 17; i++) push_tx(spi_host_pkg::byte_t'(i));
    check("overflow status", 3'b010, err_status_o);
    cycles_wait(1);
    check("overflow irq", 1, int'(intr_error_o));
    clear_errors(3'b010);
    cycles_wait(1);
    check("irq after clear", 0, int'(intr_error_o));
    pop_rx(b);
    check("underflow status", 3'b100, err_status_o);
    cycles_wait(1);
    check("underflow irq", 1, int'(intr_error_o));
    clear_errors(3'b100);
    for (int i = 0; i < 5; i++) push_cmd(1, spi_host_pkg::DirTx, 1'b0);
    check("busy status", 3'b001, err_status_o);
    check("ready when full", 0, int'(ready_o));
    spien_i = 1'b1;
    for (int i = 0; i < 20; i++) begin
      @(negedge clk_i);
      check("halted", 0, int'(active_o));
    end
    check("busy irq masked", 0, int'(intr_error_o));
    clear_errors(3'b001);
    drain_queue();
    check("tx left", 12, int'(tx_qd_o));

    test_name = "idle event";
    event_enable_i = 6'b000001;
    cycles_wait(2);
    check("idle irq", 1, int'(intr_spi_event_o));
    push_cmd(2, spi_host_pkg::DirTx, 1'b0);
    while (!active_o) @(negedge clk_i);
    cycles_wait(2);
    check("busy irq", 0, int'(intr_spi_event_o));
    drain_queue();
    cycles_wait(2);
    check("idle irq again", 1, int'(intr_spi_event_o));

    test_name = "rx watermark event";
    event_enable_i = 6'b001000;
    cycles_wait(2);
    check("below wm", 0, int'(intr_spi_event_o));
    push_cmd(3, spi_host_pkg::DirRx, 1'b0);
    drain_queue();
    cycles_wait(2);
    check("at wm", 1, int'(intr_spi_event_o));
    for (int i = 0; i < 3; i++) pop_rx(b);
    event_enable_i = '0;

    test_name = "software reset";
    push_cmd(1, spi_host_pkg::DirRx, 1'b1);
    while (rx_qd_o == '0) @(negedge clk_i);
    cycles_wait(4);
    check("csb held", 0, int'(csb_o));
    spien_i = 1'b0;
    // The fifth command finds the queue full and sets the busy bit
    for (int i = 0; i < 5; i++) push_cmd(1, spi_host_pkg::DirTx, 1'b0);
    sw_rst_i = 1'b1;
    cycles_wait(2);
    sw_rst_i = 1'b0;
    check("cmd depth", 0, int'(cmd_qd_o));
    check("tx depth", 0, int'(tx_qd_o));
    check("rx depth", 0, int'(rx_qd_o));
    check("rx valid", 0, int'(rx_valid_o));
    check("csb", 1, int'(csb_o));
    check("status kept", 3'b001, err_status_o);
    clear_errors(3'b001);
    cycles_wait(4);

    $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
logic/spi_host_pkg.sv
logic/spi_host_cmd_queue.sv
logic/spi_host_byte_fifo.sv
logic/spi_host_shift_engine.sv
logic/spi_host_irq.sv
logic/spi_host.sv
bench/spi_host_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and decide the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module spi_host_tb -f sim.f -o spi_host_sim > build.log 2>&1 &&
  ./obj_dir/spi_host_sim > sim.log 2>&1
cat build.log sim.log 2> /dev/null | tail -n 20
grep -q "TESTBENCH PASSED" sim.log 2> /dev/null && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
